// File: cpu_macros.svh
// global width, size and latency constants for the integer execution pipeline
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and immediate widths
`define XLEN 32
`define IMM_W 12

// register file
`define REG_NUM 32
`define REG_AW 5

// instruction queue depth and sender credits
`define INST_CREDITS 4

// word-addressed data memory
`define DMEM_WORDS 64
`define DMEM_AW 6
`define MEM_LATENCY 3

`endif

// File: cpu_pkg.sv
// opcode, unit and memory-state encodings plus the structs passed between stages
`include "cpu_macros.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SLL  = 4'd6,
        OP_SRL  = 4'd7,
        OP_ADDI = 4'd8,
        OP_LW   = 4'd9,
        OP_SW   = 4'd10
    } opcode_e;

    // execution unit picked at issue
    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,
        UNIT_ALU  = 2'd1,
        UNIT_MEM  = 2'd2
    } unit_e;

    typedef enum logic {
        MEM_IDLE = 1'b0,
        MEM_BUSY = 1'b1
    } mem_state_e;

    // instruction as delivered by the sender
    typedef struct packed {
        opcode_e            opcode;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`IMM_W-1:0]  imm;
    } inst_t;

    // operation handed to an execution unit, operands already read
    typedef struct packed {
        logic               valid;
        opcode_e            op;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   rs1_data;
        logic [`XLEN-1:0]   rs2_data;
        logic [`IMM_W-1:0]  imm;
    } issue_t;

    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } wb_t;

endpackage

// File: reg_file.sv
// two-read one-write register file with r0 fixed at zero and write-through reads
`timescale 1ns/10ps
`include "cpu_macros.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic [`REG_AW-1:0] rs1_addr,
    input  logic [`REG_AW-1:0] rs2_addr,
    output logic [`XLEN-1:0]   rs1_data,
    output logic [`XLEN-1:0]   rs2_data,
    input  cpu_pkg::wb_t       wb
);

    logic [`XLEN-1:0] regs [`REG_NUM];
    logic             wr_en;

    // r0 never takes a write
    assign wr_en = wb.valid && (wb.rd != '0);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // a read in the writeback cycle sees the value being written
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (wr_en && (wb.rd == rs1_addr)) begin
            rs1_data = wb.data;
        end else begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (wr_en && (wb.rd == rs2_addr)) begin
            rs2_data = wb.data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

// File: issue_stage.sv
// issue stage with instruction queue, scoreboard, operand read and unit dispatch
`timescale 1ns/10ps
`include "cpu_macros.svh"

module issue_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid,
    input  cpu_pkg::inst_t  inst,
    output logic            credit_return,
    input  cpu_pkg::wb_t    wb,
    input  logic            mem_busy,
    input  logic            alu_hold,
    output cpu_pkg::issue_t alu_op,
    output cpu_pkg::issue_t mem_op
);

    import cpu_pkg::*;

    localparam int QW  = $clog2(`INST_CREDITS);
    localparam int LDW = $clog2(`MEM_LATENCY + 1);

    inst_t               queue [`INST_CREDITS];
    logic [QW-1:0]       wr_ptr;
    logic [QW-1:0]       rd_ptr;
    logic [QW:0]         count;
    inst_t               head;
    logic                head_valid;
    logic [`REG_NUM-1:0] pending;
    unit_e               unit;
    logic                use_rs1, use_rs2, use_rd;
    logic                rs1_busy, rs2_busy, rd_busy;
    logic                unit_ready;
    logic                dispatch;
    logic                sets_rd;
    logic [`XLEN-1:0]    rs1_data;
    logic [`XLEN-1:0]    rs2_data;
    logic [LDW-1:0]      load_due;
    issue_t              slot;

    assign head       = queue[rd_ptr];
    assign head_valid = (count != '0);

    // decode the queue head into unit and register usage
    always_comb begin
        unit    = UNIT_NONE;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd  = 1'b0;
        case (head.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL: begin
                unit    = UNIT_ALU;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rd  = 1'b1;
            end
            OP_ADDI: begin
                unit    = UNIT_ALU;
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
            end
            OP_LW: begin
                unit    = UNIT_MEM;
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
            end
            OP_SW: begin
                unit    = UNIT_MEM;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            default: ;
        endcase
    end

    // a register written back this cycle already counts as free
    assign rs1_busy = use_rs1 && pending[head.rs1] && !(wb.valid && wb.rd == head.rs1);
    assign rs2_busy = use_rs2 && pending[head.rs2] && !(wb.valid && wb.rd == head.rs2);
    assign rd_busy  = use_rd && pending[head.rd] && !(wb.valid && wb.rd == head.rd);

    // an ALU op picked one cycle before a load result would land on the hold drain
    always_comb begin
        case (unit)
            UNIT_ALU: unit_ready = !alu_hold && (load_due != LDW'(1));
            UNIT_MEM: unit_ready = !mem_busy;
            default:  unit_ready = 1'b1;
        endcase
    end

    assign dispatch      = head_valid && !rs1_busy && !rs2_busy && !rd_busy && unit_ready;
    assign credit_return = dispatch;
    assign sets_rd       = use_rd && (head.rd != '0);

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            queue[wr_ptr] <= inst;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            pending  <= '0;
            load_due <= '0;
        end else begin
            if (inst_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (dispatch) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (QW+1)'(inst_valid) - (QW+1)'(dispatch);
            // set after clear so a freed rd can be claimed again at once
            if (wb.valid) begin
                pending[wb.rd] <= 1'b0;
            end
            if (dispatch && sets_rd) begin
                pending[head.rd] <= 1'b1;
            end
            if (dispatch && sets_rd && (head.opcode == OP_LW)) begin
                load_due <= LDW'(`MEM_LATENCY);
            end else if (load_due != '0) begin
                load_due <= load_due - 1'b1;
            end
        end
    end

    always_comb begin
        slot.valid    = dispatch;
        slot.op       = head.opcode;
        slot.rd       = head.rd;
        slot.rs1_data = rs1_data;
        slot.rs2_data = rs2_data;
        slot.imm      = head.imm;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            alu_op <= '0;
            mem_op <= '0;
        end else begin
            alu_op <= (unit == UNIT_ALU) ? slot : '0;
            mem_op <= (unit == UNIT_MEM) ? slot : '0;
        end
    end

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (head.rs1),
        .rs2_addr (head.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

endmodule

// File: ex_alu.sv
// ALU execution unit producing a registered writeback one cycle after the op
`timescale 1ns/10ps
`include "cpu_macros.svh"

module ex_alu (
    input  logic            clk,
    input  logic            rst,
    input  cpu_pkg::issue_t alu_op,
    output cpu_pkg::wb_t    alu_res
);

    import cpu_pkg::*;

    localparam int SHW = $clog2(`XLEN);

    logic [`XLEN-1:0] imm_ext;
    logic [`XLEN-1:0] result;
    logic             writes;

    assign imm_ext = {{(`XLEN-`IMM_W){alu_op.imm[`IMM_W-1]}}, alu_op.imm};

    always_comb begin
        writes = 1'b1;
        case (alu_op.op)
            OP_ADD:  result = alu_op.rs1_data + alu_op.rs2_data;
            OP_SUB:  result = alu_op.rs1_data - alu_op.rs2_data;
            OP_AND:  result = alu_op.rs1_data & alu_op.rs2_data;
            OP_OR:   result = alu_op.rs1_data | alu_op.rs2_data;
            OP_XOR:  result = alu_op.rs1_data ^ alu_op.rs2_data;
            // shift amount is the low bits of rs2 only
            OP_SLL:  result = alu_op.rs1_data << alu_op.rs2_data[SHW-1:0];
            OP_SRL:  result = alu_op.rs1_data >> alu_op.rs2_data[SHW-1:0];
            OP_ADDI: result = alu_op.rs1_data + imm_ext;
            default: begin
                result = '0;
                writes = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            alu_res <= '0;
        end else begin
            // no writeback for r0 targets
            alu_res.valid <= alu_op.valid && writes && (alu_op.rd != '0);
            alu_res.rd    <= alu_op.rd;
            alu_res.data  <= result;
        end
    end

endmodule

// File: ex_mem.sv
// load/store unit with a word-addressed data memory and fixed-latency loads
`timescale 1ns/10ps
`include "cpu_macros.svh"

module ex_mem (
    input  logic            clk,
    input  logic            rst,
    input  cpu_pkg::issue_t mem_op,
    output logic            mem_busy,
    output cpu_pkg::wb_t    mem_res
);

    import cpu_pkg::*;

    localparam int CW = $clog2(`MEM_LATENCY);

    logic [`XLEN-1:0]    dmem [`DMEM_WORDS];
    mem_state_e          state;
    logic [CW-1:0]       cnt;
    logic [`XLEN-1:0]    ea;
    logic [`DMEM_AW-1:0] addr;
    logic [`DMEM_AW-1:0] addr_q;
    logic [`REG_AW-1:0]  rd_q;
    logic                accept;

    assign ea = mem_op.rs1_data + {{(`XLEN-`IMM_W){mem_op.imm[`IMM_W-1]}}, mem_op.imm};
    // word index wraps modulo the memory size
    assign addr     = ea[`DMEM_AW-1:0];
    assign accept   = mem_op.valid && (state == MEM_IDLE);
    assign mem_busy = (state == MEM_BUSY) || mem_op.valid;

    // stores complete in the accepting cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (accept && (mem_op.op == OP_SW)) begin
            dmem[addr] <= mem_op.rs2_data;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= MEM_IDLE;
            cnt     <= '0;
            addr_q  <= '0;
            rd_q    <= '0;
            mem_res <= '0;
        end else begin
            mem_res.valid <= 1'b0;
            case (state)
                MEM_IDLE: begin
                    if (accept && (mem_op.op == OP_LW)) begin
                        state  <= MEM_BUSY;
                        cnt    <= CW'(1);
                        addr_q <= addr;
                        rd_q   <= mem_op.rd;
                    end
                end
                MEM_BUSY: begin
                    // last busy cycle, result shows up next cycle
                    if (cnt == CW'(`MEM_LATENCY - 1)) begin
                        state         <= MEM_IDLE;
                        mem_res.valid <= (rd_q != '0);
                        mem_res.rd    <= rd_q;
                        mem_res.data  <= dmem[addr_q];
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

endmodule

// File: wb_arbiter.sv
// writeback arbiter with load priority and a one-entry hold for a displaced ALU result
`timescale 1ns/10ps

module wb_arbiter (
    input  logic         clk,
    input  logic         rst,
    input  cpu_pkg::wb_t alu_res,
    input  cpu_pkg::wb_t mem_res,
    output cpu_pkg::wb_t wb,
    output logic         alu_hold
);

    import cpu_pkg::*;

    wb_t  hold_q;
    logic collide;

    // load and ALU results in the same cycle
    assign collide  = mem_res.valid && alu_res.valid;
    assign alu_hold = hold_q.valid;

    always_comb begin
        if (mem_res.valid) begin
            wb = mem_res;
        end else if (hold_q.valid) begin
            // parked result drains the cycle after the collision
            wb = hold_q;
        end else begin
            wb = alu_res;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hold_q <= '0;
        end else begin
            hold_q <= collide ? alu_res : '0;
        end
    end

endmodule

// File: cpu_pipeline.sv
// top level of the integer execution pipeline connecting issue, execute and writeback
`timescale 1ns/10ps

module cpu_pipeline (
    input  logic           clk,
    input  logic           rst,
    input  logic           inst_valid,
    input  cpu_pkg::inst_t inst,
    output logic           credit_return,
    output cpu_pkg::wb_t   wb
);

    import cpu_pkg::*;

    issue_t alu_op;
    issue_t mem_op;
    wb_t    alu_res;
    wb_t    mem_res;
    logic   mem_busy;
    logic   alu_hold;

    issue_stage u_issue (
        .clk           (clk),
        .rst           (rst),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .credit_return (credit_return),
        .wb            (wb),
        .mem_busy      (mem_busy),
        .alu_hold      (alu_hold),
        .alu_op        (alu_op),
        .mem_op        (mem_op)
    );

    ex_alu u_alu (
        .clk     (clk),
        .rst     (rst),
        .alu_op  (alu_op),
        .alu_res (alu_res)
    );

    ex_mem u_mem (
        .clk      (clk),
        .rst      (rst),
        .mem_op   (mem_op),
        .mem_busy (mem_busy),
        .mem_res  (mem_res)
    );

    // load results win, the ALU result waits one cycle
    wb_arbiter u_wb (
        .clk      (clk),
        .rst      (rst),
        .alu_res  (alu_res),
        .mem_res  (mem_res),
        .wb       (wb),
        .alu_hold (alu_hold)
    );

endmodule

// File: cpu_pipeline_assert.sv
// concurrent checks on outstanding credits, writeback targets and ALU hold length
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_pipeline_assert (
    input logic         clk,
    input logic         rst,
    input logic         inst_valid,
    input logic         credit_return,
    input logic         alu_hold,
    input cpu_pkg::wb_t wb
);

    // accepted but not yet dispatched
    logic [3:0] outstanding;
    // number of failed assertions
    int         fail_count = 0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 4'(inst_valid) - 4'(credit_return);
        end
    end

    credit_limit: assert property (@(posedge clk) disable iff (!rst)
        outstanding <= 4'(`INST_CREDITS))
        else begin
            fail_count++;
            $error("more instructions outstanding than credits");
        end

    no_r0_wb: assert property (@(posedge clk) disable iff (!rst)
        wb.valid |-> (wb.rd != '0))
        else begin
            fail_count++;
            $error("writeback targets r0");
        end

    // parked ALU result must drain the next cycle
    hold_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        alu_hold |=> !alu_hold)
        else begin
            fail_count++;
            $error("alu_hold high for two cycles in a row");
        end

endmodule

// File: tb_cpu_pipeline.sv
// table-driven testbench for the integer pipeline with credit-based sender and reference model
`timescale 1ns/10ps
`include "cpu_macros.svh"

module tb_cpu_pipeline;

    import cpu_pkg::*;

    localparam int RW = `REG_AW;
    localparam int IW = `IMM_W;
    localparam int AW = `DMEM_AW;

    // one table row: sequence number plus the instruction to send
    typedef struct packed {
        logic [3:0] seq;
        inst_t      inst;
    } step_t;

    logic  clk;
    logic  rst;
    logic  inst_valid;
    inst_t inst;
    logic  credit_return;
    wb_t   wb;

    step_t            prog [$];
    wb_t              exp_q [$];
    logic [`XLEN-1:0] model_reg [`REG_NUM];
    logic [`XLEN-1:0] model_mem [`DMEM_WORDS];
    logic [31:0]      lfsr;
    int               sent;
    int               returned;
    int               mismatches;
    int               failures;
    logic             timed_out;

    cpu_pipeline uut (
        .clk           (clk),
        .rst           (rst),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .credit_return (credit_return),
        .wb            (wb)
    );

    bind cpu_pipeline cpu_pipeline_assert u_assert (
        .clk           (clk),
        .rst           (rst),
        .inst_valid    (inst_valid),
        .credit_return (credit_return),
        .alu_hold      (alu_hold),
        .wb            (wb)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_random(input int nbits, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < nbits; b++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            mismatches++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t",
                     name, got, want, $time);
        end
    endtask

    task automatic add_step(input int seq, input opcode_e op, input int rd,
                            input int rs1, input int rs2, input int imm);
        step_t s;
        s.seq         = 4'(seq);
        s.inst.opcode = op;
        s.inst.rd     = RW'(rd);
        s.inst.rs1    = RW'(rs1);
        s.inst.rs2    = RW'(rs2);
        s.inst.imm    = IW'(imm);
        prog.push_back(s);
    endtask

    task automatic build_table();
        // ALU opcodes, negative immediates, shifts by 31 and 33
        add_step(1, OP_ADDI, 1, 0, 0, 'h123);
        add_step(1, OP_ADDI, 2, 0, 0, -5);
        add_step(1, OP_ADD, 3, 1, 2, 0);
        add_step(1, OP_SUB, 4, 1, 2, 0);
        add_step(1, OP_AND, 5, 1, 2, 0);
        add_step(1, OP_OR, 6, 1, 2, 0);
        add_step(1, OP_XOR, 7, 1, 2, 0);
        add_step(1, OP_ADDI, 8, 0, 0, 31);
        add_step(1, OP_SLL, 9, 2, 8, 0);
        add_step(1, OP_SRL, 10, 2, 8, 0);
        add_step(1, OP_ADDI, 11, 0, 0, 33);
        add_step(1, OP_SRL, 12, 2, 11, 0);
        add_step(1, OP_SLL, 13, 1, 11, 0);
        add_step(1, OP_ADDI, 28, 1, 0, -2048);
        // dependent chain, RAW and WAW
        add_step(2, OP_ADDI, 14, 1, 0, 1);
        add_step(2, OP_ADD, 14, 14, 14, 0);
        add_step(2, OP_ADD, 15, 14, 1, 0);
        add_step(2, OP_SUB, 15, 15, 14, 0);
        add_step(2, OP_SLL, 15, 15, 14, 0);
        // store then load, plain and wrapped addresses
        add_step(3, OP_SW, 0, 0, 1, 5);
        add_step(3, OP_LW, 16, 0, 0, 5);
        add_step(3, OP_SW, 0, 8, 3, 40);
        add_step(3, OP_LW, 17, 0, 0, 7);
        add_step(3, OP_LW, 18, 8, 0, -24);
        add_step(3, OP_SW, 0, 2, 7, 0);
        add_step(3, OP_LW, 19, 0, 0, 59);
        // independent ALU work behind a load
        add_step(4, OP_LW, 20, 0, 0, 5);
        add_step(4, OP_ADDI, 21, 1, 0, 2);
        add_step(4, OP_ADD, 22, 2, 3, 0);
        add_step(4, OP_XOR, 23, 4, 5, 0);
        add_step(4, OP_OR, 24, 6, 7, 0);
        add_step(4, OP_SUB, 25, 9, 10, 0);
        // users and overwriters of a load result
        add_step(5, OP_LW, 26, 0, 0, 7);
        add_step(5, OP_ADD, 27, 26, 1, 0);
        add_step(5, OP_LW, 29, 0, 0, 59);
        add_step(5, OP_ADDI, 29, 0, 0, 9);
        add_step(5, OP_ADD, 30, 29, 26, 0);
        // r0 writes, nop and quick dependent adds
        add_step(6, OP_ADDI, 0, 1, 0, 5);
        add_step(6, OP_ADD, 31, 0, 1, 0);
        add_step(6, OP_LW, 0, 0, 0, 5);
        add_step(6, OP_SLL, 0, 1, 8, 0);
        add_step(6, OP_NOP, 0, 0, 0, 0);
        add_step(6, OP_ADDI, 3, 3, 0, 1);
        add_step(6, OP_ADDI, 3, 3, 0, 1);
        add_step(6, OP_XOR, 31, 31, 0, 0);
    endtask

    // program-order model, queues the register write this instruction makes
    task automatic model_step(input inst_t i);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm_ext;
        logic [`XLEN-1:0] ea;
        logic [`XLEN-1:0] val;
        logic             writes;
        wb_t              e;
        a       = model_reg[i.rs1];
        b       = model_reg[i.rs2];
        imm_ext = {{(`XLEN-IW){i.imm[IW-1]}}, i.imm};
        ea      = a + imm_ext;
        val     = '0;
        writes  = 1'b1;
        case (i.opcode)
            OP_ADD:  val = a + b;
            OP_SUB:  val = a - b;
            OP_AND:  val = a & b;
            OP_OR:   val = a | b;
            OP_XOR:  val = a ^ b;
            OP_SLL:  val = a << b[4:0];
            OP_SRL:  val = a >> b[4:0];
            OP_ADDI: val = a + imm_ext;
            OP_LW:   val = model_mem[ea[AW-1:0]];
            OP_SW: begin
                model_mem[ea[AW-1:0]] = b;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes && (i.rd != '0)) begin
            model_reg[i.rd] = val;
            e.valid = 1'b1;
            e.rd    = i.rd;
            e.data  = val;
            exp_q.push_back(e);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        while ((exp_q.size() != 0) || (returned != sent)) begin
            next_cycle();
        end
    endtask

    task automatic send_program();
        logic [31:0] r;
        int          gap;
        for (int i = 0; i < prog.size(); i++) begin
            if ((i > 0) && (prog[i].seq != prog[i-1].seq)) begin
                wait_drain();
            end
            take_random(2, r);
            gap = r[1] ? int'(r[0]) + 1 : 0;
            repeat (gap) next_cycle();
            // no credit left, wait for one to come back
            while ((sent - returned) >= `INST_CREDITS) begin
                next_cycle();
            end
            model_step(prog[i].inst);
            inst_valid = 1'b1;
            inst       = prog[i].inst;
            sent++;
            next_cycle();
            inst_valid = 1'b0;
        end
    endtask

    task automatic watch_outputs();
        int idx;
        forever begin
            @(negedge clk);
            if (credit_return) begin
                returned++;
            end
            if (wb.valid) begin
                idx = -1;
                for (int k = 0; k < exp_q.size(); k++) begin
                    if ((idx < 0) && (exp_q[k].rd == wb.rd)) begin
                        idx = k;
                    end
                end
                if (wb.rd == '0) begin
                    failures++;
                    $display("writeback to r0 seen at %0t", $time);
                end else if (idx < 0) begin
                    failures++;
                    $display("unexpected writeback to r%0d at %0t", wb.rd, $time);
                end else begin
                    check_value($sformatf("wb.data r%0d", wb.rd), wb.data, exp_q[idx].data);
                    exp_q.delete(idx);
                end
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        lfsr       = 32'h73cd;
        sent       = 0;
        returned   = 0;
        mismatches = 0;
        failures   = 0;
        timed_out  = 1'b0;
        for (int r = 0; r < `REG_NUM; r++) begin
            model_reg[r] = '0;
        end
        for (int m = 0; m < `DMEM_WORDS; m++) begin
            model_mem[m] = '0;
        end
        build_table();
        fork
            begin
                repeat (3) @(posedge clk);
                #1 rst = 1'b1;
                send_program();
                wait_drain();
                repeat (8) next_cycle();
            end
            watch_outputs();
            begin
                repeat (prog.size() * 20) @(posedge clk);
                timed_out = 1'b1;
            end
        join_any
        if (timed_out) begin
            failures++;
            $display("watchdog expired with %0d of %0d instructions sent", sent, prog.size());
        end
        if (exp_q.size() != 0) begin
            failures++;
            $display("%0d expected writebacks never arrived", exp_q.size());
        end
        if (uut.u_assert.fail_count != 0) begin
            failures += uut.u_assert.fail_count;
            $display("%0d assertion failures in the bound checker",
                     uut.u_assert.fail_count);
        end
        check_value("credit_return count", returned, sent);
        $display("Summary: %0d mismatches, %0d other errors, %0d instructions sent",
                 mismatches, failures, sent);
        if ((mismatches + failures) == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
cpu_pkg.sv
reg_file.sv
issue_stage.sv
ex_alu.sv
ex_mem.sv
wb_arbiter.sv
cpu_pipeline.sv
cpu_pipeline_assert.sv
tb_cpu_pipeline.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cpu_pipeline
FILELIST = vlog.f
OBJDIR   = obj_dir

SOURCES  = $(shell grep -v '^+' $(FILELIST)) cpu_macros.svh
BIN      = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "^Done: no errors$$"

clean:
	rm -rf $(OBJDIR)
